// File: spi_loop.f
source/spi_pkg.sv
source/spi_clk_gen.sv
source/spi_shift_reg.sv
source/spi_master_fsm.sv
source/spi_slave.sv
source/spi_loop_top.sv
dv/spi_loop_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SPI loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    --top-module spi_loop_tb -f spi_loop.f -o Vspi_loop_tb \
    || { echo "Build failed"; exit 1; }

./obj_dir/Vspi_loop_tb > "$LOG" 2>&1 \
    || { cat "$LOG"; echo "Simulation ended abnormally"; exit 1; }

cat "$LOG"
grep -q "RESULT: FAIL" "$LOG" && { echo "Test failed"; exit 1; } || echo "Test passed"

// File: dv/spi_loop_tb.sv
`timescale 1ns/10ps

module spi_loop_tb;
    import spi_pkg::*;

    // --------------------------------------------------
    // Run length and timing
    // --------------------------------------------------
    localparam int CLK_PERIOD   = 100;   // ns
    localparam int RESET_CYCLES = 16;
    localparam int NUM_FRAMES   = 40;
    localparam int FRAME_BOUND  = 200;   // Generous cycles per frame incl. idle
    localparam int TIMEOUT_NS   = (NUM_FRAMES * FRAME_BOUND + RESET_CYCLES) * CLK_PERIOD;

    // DUT side
    logic     pllClk_i;
    logic     rst_n_i;
    logic     send_n_i;
    byte_t    master_tx_i;
    byte_t    slave_tx_i;
    logic     ready_o;
    logic     done_o;
    byte_t    master_rx_o;
    byte_t    slave_rx_o;
    spi_bus_t bus_o;
    logic     miso_o;

    // Reference model and bookkeeping
    integer   seed;
    int       err_cnt;
    int       accept_cnt;
    int       done_cnt;
    byte_t    exp_master_q[$];   // Expected at the slave, one per accepted frame
    byte_t    exp_slave_q[$];    // Expected at the master
    byte_t    cur_master;        // Byte shifting out on mosi
    byte_t    cur_slave;         // Byte shifting out on miso
    int       rise_cnt;          // sclk rises in the current frame
    logic     ss_n_prev;
    logic     sclk_prev;
    logic     done_prev;

    initial pllClk_i = 1'b0;
    always #(CLK_PERIOD / 2) pllClk_i = ~pllClk_i;

    spi_loop_top UUT (
        .pllClk_i    (pllClk_i),
        .rst_n_i     (rst_n_i),
        .send_n_i    (send_n_i),
        .master_tx_i (master_tx_i),
        .slave_tx_i  (slave_tx_i),
        .ready_o     (ready_o),
        .done_o      (done_o),
        .master_rx_o (master_rx_o),
        .slave_rx_o  (slave_rx_o),
        .bus_o       (bus_o),
        .miso_o      (miso_o)
    );

    // --------------------------------------------------
    // Checking helpers
    // --------------------------------------------------
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Bus and handshake idle levels
    task automatic check_idle_state();
        check_value(32'(bus_o.ss_n), 32'd1, "ss_n after reset");
        check_value(32'(bus_o.sclk), 32'd0, "sclk after reset");
        check_value(32'(ready_o), 32'd1, "ready_o after reset");
        check_value(32'(done_o), 32'd0, "done_o after reset");
    endtask

    // --------------------------------------------------
    // Bus monitor, sampled mid-cycle where all is settled
    // --------------------------------------------------
    always @(negedge pllClk_i) begin
        if (rst_n_i) begin
            if (done_o) begin
                done_cnt++;
                if (done_prev) begin
                    report_error("done_o stayed high for more than one cycle");
                end
                if (exp_master_q.size() == 0) begin
                    report_error("done_o pulsed without an accepted frame");
                end else begin
                    check_value(32'(slave_rx_o), 32'(exp_master_q.pop_front()),
                                "slave_rx_o at done");
                    check_value(32'(master_rx_o), 32'(exp_slave_q.pop_front()),
                                "master_rx_o at done");
                end
            end
            // Select edges, sclk parked low at both
            if (ss_n_prev && !bus_o.ss_n) begin
                check_value(32'(bus_o.sclk), 32'd0, "sclk level at ss_n fall");
                check_value(32'(exp_master_q.size()), 32'd1, "frames in flight at ss_n fall");
                rise_cnt = 0;
            end
            if (!ss_n_prev && bus_o.ss_n) begin
                check_value(32'(bus_o.sclk), 32'd0, "sclk level at ss_n rise");
                check_value(32'(rise_cnt), 32'(DATA_BITS), "sclk rises in frame");
            end
            // Reply line quiet outside a frame
            if (bus_o.ss_n) begin
                check_value(32'(miso_o), 32'd0, "miso while deselected");
            end
            if (!sclk_prev && bus_o.sclk) begin
                if (bus_o.ss_n) begin
                    report_error("sclk rose while ss_n was high");
                end else begin
                    if (rise_cnt < DATA_BITS) begin   // MSB first
                        check_value(32'(bus_o.mosi), 32'(cur_master[DATA_BITS - 1 - rise_cnt]),
                                    "mosi bit at sclk rise");
                        check_value(32'(miso_o), 32'(cur_slave[DATA_BITS - 1 - rise_cnt]),
                                    "miso bit at sclk rise");
                    end
                    rise_cnt++;
                end
            end
            // Start taken on the coming edge
            if (ready_o && !send_n_i) begin
                exp_master_q.push_back(master_tx_i);
                exp_slave_q.push_back(slave_tx_i);
                cur_master = master_tx_i;
                cur_slave  = slave_tx_i;
                accept_cnt++;
            end
        end
        ss_n_prev = bus_o.ss_n;
        sclk_prev = bus_o.sclk;
        done_prev = done_o;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic run_frame();
        int idle;
        int offset;
        idle = $unsigned($random(seed)) % 8;
        repeat (idle) @(posedge pllClk_i);
        @(posedge pllClk_i);
        master_tx_i <= byte_t'($random(seed));
        slave_tx_i  <= byte_t'($random(seed));
        send_n_i    <= 1'b0;
        @(negedge pllClk_i);
        while (!ready_o) @(negedge pllClk_i);
        @(posedge pllClk_i);           // Accepting edge
        send_n_i <= 1'b1;
        // Stray start and fresh input bytes while busy, well after the slave load
        if (($random(seed) & 1) != 0) begin
            offset = 3 + $unsigned($random(seed)) % 50;
            repeat (offset) @(posedge pllClk_i);
            send_n_i    <= 1'b0;
            master_tx_i <= byte_t'($random(seed));
            slave_tx_i  <= byte_t'($random(seed));
            @(posedge pllClk_i);
            send_n_i <= 1'b1;
        end
        @(negedge pllClk_i);
        while (!done_o) @(negedge pllClk_i);
    endtask

    initial begin
        seed        = 32'h4e8f_66b9;
        err_cnt     = 0;
        accept_cnt  = 0;
        done_cnt    = 0;
        rise_cnt    = 0;
        cur_master  = '0;
        cur_slave   = '0;
        ss_n_prev   = 1'b1;
        sclk_prev   = 1'b0;
        done_prev   = 1'b0;
        rst_n_i     = 1'b0;
        send_n_i    = 1'b1;
        master_tx_i = '0;
        slave_tx_i  = '0;
        repeat (RESET_CYCLES) @(posedge pllClk_i);
        rst_n_i <= 1'b1;
        @(negedge pllClk_i);
        check_idle_state();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            run_frame();
        end
        repeat (4) @(negedge pllClk_i);   // Let the last frame settle
        check_value(32'(accept_cnt), 32'(NUM_FRAMES), "accepted frames");
        check_value(32'(done_cnt), 32'(NUM_FRAMES), "done pulses");
        check_value(32'(exp_master_q.size()), 32'd0, "frames left in model");
        $display("Summary: %0d frames done, %0d errors", done_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: run timed out after %0d ns, the DUT stopped finishing frames",
                 TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: source/spi_loop_top.sv
`timescale 1ns/10ps

module spi_loop_top (
    input  logic              pllClk_i,      // System clock
    input  logic              rst_n_i,       // Async reset, active low
    input  logic              send_n_i,      // Start request, active low
    input  spi_pkg::byte_t    master_tx_i,   // Master to slave byte
    input  spi_pkg::byte_t    slave_tx_i,    // Slave to master byte
    output logic              ready_o,
    output logic              done_o,
    output spi_pkg::byte_t    master_rx_o,   // Byte the master got
    output spi_pkg::byte_t    slave_rx_o,    // Byte the slave got
    output spi_pkg::spi_bus_t bus_o,         // Bus for observation
    output logic              miso_o
);
    import spi_pkg::*;

    // ------------------------------------------------
    // Link wires
    // ------------------------------------------------
    spi_bus_t bus;    // Master toward slave
    logic     miso;   // Slave toward master

    // Master end with its clock generator
    spi_master_fsm u_master (
        .pllClk_i  (pllClk_i),
        .rst_n_i   (rst_n_i),
        .send_n_i  (send_n_i),
        .tx_data_i (master_tx_i),
        .miso_i    (miso),
        .bus_o     (bus),
        .ready_o   (ready_o),
        .done_o    (done_o),
        .rx_data_o (master_rx_o)
    );

    // Slave end, same clock
    spi_slave u_slave (
        .pllClk_i  (pllClk_i),
        .rst_n_i   (rst_n_i),
        .bus_i     (bus),
        .tx_data_i (slave_tx_i),
        .miso_o    (miso),
        .rx_data_o (slave_rx_o)
    );

    // Observation taps
    assign bus_o  = bus;
    assign miso_o = miso;

endmodule

// File: source/spi_slave.sv
`timescale 1ns/10ps

module spi_slave (
    input  logic              pllClk_i,    // System clock
    input  logic              rst_n_i,     // Async reset, active low
    input  spi_pkg::spi_bus_t bus_i,       // Lines from the master
    input  spi_pkg::byte_t    tx_data_i,   // Reply byte, loaded at select
    output logic              miso_o,      // Reply line
    output spi_pkg::byte_t    rx_data_o    // Last byte from the master
);
    import spi_pkg::*;

    logic     sclk_q;      // Registered pins
    logic     ss_n_q;
    logic     selected;
    logic     sclk_rise;   // Detected one cycle after the pin moves
    logic     sclk_fall;
    logic     ss_fall;
    bit_cnt_t bit_cnt;     // Rises seen this frame
    logic     last_rise;
    logic     cap_q;       // Byte complete, copy next cycle
    logic     sr_serial;
    byte_t    sr_data;

    // ------------------------------------------------
    // Edge detection
    // ------------------------------------------------
    always_ff @(posedge pllClk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sclk_q <= 1'b0;   // Bus idle levels
            ss_n_q <= 1'b1;
        end else begin
            sclk_q <= bus_i.sclk;
            ss_n_q <= bus_i.ss_n;
        end
    end

    assign selected  = !bus_i.ss_n;
    assign sclk_rise = bus_i.sclk && !sclk_q;
    assign sclk_fall = !bus_i.sclk && sclk_q;
    assign ss_fall   = !bus_i.ss_n && ss_n_q;   // Start of frame
    assign last_rise = selected && sclk_rise && (bit_cnt == bit_cnt_t'(DATA_BITS - 1));

    // Bit count and completion flag
    always_ff @(posedge pllClk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt <= '0;
            cap_q   <= 1'b0;
        end else begin
            cap_q <= last_rise;
            if (ss_fall) begin
                bit_cnt <= '0;
            end else if (selected && sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Received byte holds until the next frame completes
    always_ff @(posedge pllClk_i) begin
        if (cap_q) begin
            rx_data_o <= sr_data;   // Held bit already in from the eighth rise
        end
    end

    // ------------------------------------------------
    // Shift register and reply line
    // ------------------------------------------------
    spi_shift_reg u_shift (
        .pllClk_i    (pllClk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (ss_fall),
        .load_data_i (tx_data_i),
        .sample_i    (selected && sclk_rise),   // Mosi captured on rise
        .shift_i     (selected && sclk_fall),   // Next bit out on fall
        .serial_i    (bus_i.mosi),
        .serial_o    (sr_serial),
        .data_o      (sr_data)
    );

    assign miso_o = selected ? sr_serial : 1'b0;   // Quiet while deselected

    // sclk must stay parked outside a frame
    a_sclk_sel : assert property (
        @(posedge pllClk_i) disable iff (!rst_n_i)
        (sclk_rise || sclk_fall) |-> selected
    ) else $error("spi_slave: sclk edge while deselected");

endmodule

// File: source/spi_master_fsm.sv
`timescale 1ns/10ps

module spi_master_fsm (
    input  logic              pllClk_i,    // System clock
    input  logic              rst_n_i,     // Async reset, active low
    input  logic              send_n_i,    // Start request, active low level
    input  spi_pkg::byte_t    tx_data_i,   // Byte toward the slave
    input  logic              miso_i,      // Slave reply line
    output spi_pkg::spi_bus_t bus_o,       // sclk, mosi, ss_n
    output logic              ready_o,     // Idle, start accepted
    output logic              done_o,      // One-cycle end of frame
    output spi_pkg::byte_t    rx_data_o    // Byte from the slave
);
    import spi_pkg::*;

    master_state_e state;
    master_state_e state_nxt;
    bit_cnt_t      bit_cnt;     // Falls in XFER, cycles in HOLD
    logic          accept;      // Frame start this cycle
    logic          last_fall;   // Eighth fall strobe
    logic          hold_last;   // Final HOLD cycle
    logic          clk_en;
    logic          ss_n_q;
    logic          sclk;
    sclk_strobe_t  strobe;
    logic          mosi;

    assign ready_o   = (state == IDLE) || (state == DONE);
    assign done_o    = (state == DONE);
    assign accept    = ready_o && !send_n_i;   // Sends while busy dropped
    assign last_fall = strobe.fall && (bit_cnt == bit_cnt_t'(DATA_BITS - 1));
    assign hold_last = (state == HOLD) && (bit_cnt == bit_cnt_t'(SCLK_HALF - 1));

    // Clock runs SETUP through HOLD, stopped one cycle early so the
    // pending rise never reaches the pin
    assign clk_en = (state == SETUP) || (state == XFER) ||
                    ((state == HOLD) && !hold_last);

    // ------------------------------------------------
    // State machine
    // ------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept) state_nxt = SETUP;
            SETUP:   if (strobe.rise) state_nxt = XFER;   // First bit sampled here
            XFER:    if (last_fall) state_nxt = HOLD;
            HOLD:    if (hold_last) state_nxt = DONE;
            DONE:    state_nxt = accept ? SETUP : IDLE;   // Back-to-back allowed
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge pllClk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state  <= IDLE;
            ss_n_q <= 1'b1;
        end else begin
            state  <= state_nxt;
            ss_n_q <= (state_nxt == IDLE) || (state_nxt == DONE);  // Select follows state
        end
    end

    // Bit periods, then reused to time the hold half period
    always_ff @(posedge pllClk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt <= '0;
        end else if (accept) begin
            bit_cnt <= '0;
        end else if (((state == XFER) && strobe.fall) || (state == HOLD)) begin
            bit_cnt <= bit_cnt + 1'b1;   // Wraps to zero at eighth fall
        end
    end

    // ------------------------------------------------
    // Datapath
    // ------------------------------------------------
    spi_clk_gen u_clk_gen (
        .pllClk_i (pllClk_i),
        .rst_n_i  (rst_n_i),
        .en_i     (clk_en),
        .sclk_o   (sclk),
        .strobe_o (strobe)
    );

    // Last fall skipped, received byte stays whole
    spi_shift_reg u_shift (
        .pllClk_i    (pllClk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (accept),
        .load_data_i (tx_data_i),
        .sample_i    (strobe.rise),
        .shift_i     (strobe.fall && !last_fall),
        .serial_i    (miso_i),
        .serial_o    (mosi),
        .data_o      (rx_data_o)
    );

    assign bus_o.sclk = sclk;
    assign bus_o.mosi = mosi;
    assign bus_o.ss_n = ss_n_q;

    // Selected slave means no new start can be taken
    a_ready_sel : assert property (
        @(posedge pllClk_i) disable iff (!rst_n_i)
        !bus_o.ss_n |-> !ready_o
    ) else $error("spi_master_fsm: ready high while slave selected");

endmodule

// File: source/spi_shift_reg.sv
`timescale 1ns/10ps

module spi_shift_reg (
    input  logic           pllClk_i,      // System clock
    input  logic           rst_n_i,       // Async reset, active low
    input  logic           load_i,        // Parallel load, wins over shift
    input  spi_pkg::byte_t load_data_i,   // Byte to transmit
    input  logic           sample_i,      // Capture serial_i
    input  logic           shift_i,       // Shift left, insert held bit
    input  logic           serial_i,      // Incoming line
    output logic           serial_o,      // Outgoing line, MSB first
    output spi_pkg::byte_t data_o         // Assembled receive byte
);
    import spi_pkg::*;

    byte_t shreg;   // Outgoing bits at the top, received bits below
    logic  held;    // Bit sampled on the capture edge

    // ------------------------------------------------
    // Shift path
    // ------------------------------------------------
    // Sampling and shifting on opposite sclk edges, mode 0
    always_ff @(posedge pllClk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            shreg <= '0;
            held  <= 1'b0;
        end else begin
            if (load_i) begin
                shreg <= load_data_i;
            end else if (shift_i) begin
                shreg <= {shreg[DATA_BITS-2:0], held};   // Held bit enters at LSB
            end
            if (sample_i) begin
                held <= serial_i;
            end
        end
    end

    assign serial_o = shreg[DATA_BITS-1];   // MSB drives the line

    // Last sampled bit is still in held, so it completes the byte
    // without a final shift
    assign data_o = {shreg[DATA_BITS-2:0], held};

    // A load landing on a shift would drop one of them
    a_load_shift : assert property (
        @(posedge pllClk_i) disable iff (!rst_n_i)
        !(load_i && shift_i)
    ) else $error("spi_shift_reg: load and shift in the same cycle");

endmodule

// File: source/spi_clk_gen.sv
`timescale 1ns/10ps

module spi_clk_gen (
    input  logic                  pllClk_i,   // System clock
    input  logic                  rst_n_i,    // Async reset, active low
    input  logic                  en_i,       // Run sclk while high
    output logic                  sclk_o,     // sclk level, idles low
    output spi_pkg::sclk_strobe_t strobe_o    // Edge strobes
);
    import spi_pkg::*;

    half_cnt_t half_cnt;   // Position inside current half period
    logic      toggle;     // Last cycle of half period

    // Strobes lead the sclk toggle by one cycle
    assign toggle        = en_i && (half_cnt == half_cnt_t'(SCLK_HALF - 1));
    assign strobe_o.rise = toggle && !sclk_o;   // Low half ending
    assign strobe_o.fall = toggle && sclk_o;    // High half ending

    // ------------------------------------------------
    // Half period counter and sclk register
    // ------------------------------------------------
    always_ff @(posedge pllClk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            half_cnt <= '0;
            sclk_o   <= 1'b0;
        end else if (!en_i) begin
            // Parked, so every frame starts from the same phase
            half_cnt <= '0;
            sclk_o   <= 1'b0;
        end else if (toggle) begin
            half_cnt <= '0;         // Wrap
            sclk_o   <= !sclk_o;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // Edge strobes are exclusive, sclk has one level
    a_strobe_excl : assert property (
        @(posedge pllClk_i) disable iff (!rst_n_i)
        !(strobe_o.rise && strobe_o.fall)
    ) else $error("spi_clk_gen: rise and fall strobes in the same cycle");

endmodule

// File: source/spi_pkg.sv
package spi_pkg;

    // ------------------------------------------------
    // Frame and timing constants
    // ------------------------------------------------
    localparam int DATA_BITS = 8;     // Bits per frame, one byte each way
    localparam int SCLK_HALF = 4;     // pllClk_i cycles per sclk half period

    // ------------------------------------------------
    // Width types
    // ------------------------------------------------
    typedef logic [DATA_BITS-1:0]          byte_t;      // One data byte
    typedef logic [$clog2(DATA_BITS)-1:0]  bit_cnt_t;   // Bit index in frame
    typedef logic [$clog2(SCLK_HALF)-1:0]  half_cnt_t;  // Cycle in half period

    // Master sequencing
    typedef enum logic [2:0] {
        IDLE,    // Waiting for send, ready high
        SETUP,   // ss_n low, sclk low for one half period
        XFER,    // Eight full sclk periods
        HOLD,    // sclk parked low before deselect
        DONE     // One cycle, done pulse
    } master_state_e;

    // ------------------------------------------------
    // Grouped signals
    // ------------------------------------------------
    // Lines driven by the master toward the slave
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic ss_n;    // Active low select
    } spi_bus_t;

    // Single-cycle strobes, high the cycle before sclk toggles
    typedef struct packed {
        logic rise;
        logic fall;
    } sclk_strobe_t;

endpackage
